// ==== c64_host_defs.svh ====
/*
 * shared constants for the host control plane: bus widths, region
 * nibbles, register offsets, memory depths, OSD colours, phase counter
 */
`ifndef C64_HOST_DEFS_SVH
`define C64_HOST_DEFS_SVH

// host bus
`define HOST_ADDR_W 32
`define HOST_DATA_W 32

// region select, top address nibble
`define REGION_ROM_TOP 4'h0
`define REGION_WORK    4'h1
`define REGION_PAD     4'h2
`define REGION_CTRL    4'h3

// loader window, upper 16 address bits
`define LOADER_BASE_HI 16'h5000

// offsets inside a region (addr[27:0])
`define PAD1_OFS        28'h000_0000
`define PAD2_OFS        28'h000_0004
`define CTRL_OSD_OFS    28'h000_0000
`define CTRL_KBD_LO_OFS 28'h000_0004
`define CTRL_KBD_HI_OFS 28'h000_0008
`define CTRL_CORE_OFS   28'h000_000c

// memory depths
`define WORK_AW 8
`define MAIN_AW 16

// osd colours
`define OSD_FG_RGB 24'hff_ff_ff
`define OSD_BG_RGB 24'h30_40_50

`define PHASE_CNT_W 3

`endif

// ==== host_bus_pkg.sv ====
/*
 * host bus request and response structs, region enum
 * and the 1 MHz phase enable pair
 */
`include "c64_host_defs.svh"

package host_bus_pkg;

  // master to slave, held until ready is seen
  typedef struct packed {
    logic                      valid;
    logic [`HOST_ADDR_W-1:0]   addr;
    logic [`HOST_DATA_W-1:0]   wdata;
    logic [`HOST_DATA_W/8-1:0] wstrb;
  } host_req_t;

  // ready is a single-cycle pulse, rdata valid with it
  typedef struct packed {
    logic                    ready;
    logic [`HOST_DATA_W-1:0] rdata;
  } host_rsp_t;

  typedef enum logic [2:0] {
    UNMAPPED,
    WORK,
    PAD,
    CTRL,
    LOADER
  } region_e;

  // one-cycle enables, 4 cycles apart
  typedef struct packed {
    logic ph1;
    logic ph2;
  } phase_t;

endpackage

// ==== video_pkg.sv ====
/*
 * video beat struct and OSD control register layout
 */

package video_pkg;

  // one pixel clock worth of video
  typedef struct packed {
    logic [23:0] rgb;
    logic        hs;
    logic        vs;
    logic        de;
  } video_beat_t;

  // enable sits in bit 0, tall in bit 1
  typedef struct packed {
    logic tall;
    logic enable;
  } osd_ctrl_t;

endpackage

// ==== sync_ram.sv ====
/*
 * single-port synchronous ram, registered read,
 * payload type set by parameter, optional byte-lane writes
 */
`timescale 1ns/1ps

module sync_ram #(
  parameter type payload_t = logic [7:0],
  parameter int  AW        = 8,
  parameter bit  BYTE_WE   = 1'b0
) (
  input  logic          clk_8mhz,
  input  logic [AW-1:0] i_addr,
  input  payload_t      i_wdata,
  input  logic [3:0]    i_we,
  output payload_t      o_rdata
);

  localparam int W = $bits(payload_t);

  logic [W-1:0] mem [2**AW];
  logic [W-1:0] wbits;
  logic [W-1:0] q;

  assign wbits = i_wdata;

  if (BYTE_WE) begin : g_byte_we
    // one strobe bit per byte lane
    always_ff @(posedge clk_8mhz) begin
      for (int b = 0; b < W / 8; b++) begin
        if (i_we[b]) begin
          mem[i_addr][b*8 +: 8] <= wbits[b*8 +: 8];
        end
      end
    end
  end else begin : g_word_we
    always_ff @(posedge clk_8mhz) begin
      if (|i_we) begin
        mem[i_addr] <= wbits;
      end
    end
  end

  // read-first
  always_ff @(posedge clk_8mhz) begin
    q <= mem[i_addr];
  end

  assign o_rdata = payload_t'(q);

endmodule

// ==== phase_bus_ctrl.sv ====
/*
 * 1 MHz two-phase enables, region decode of the host bus,
 * per-region ready rules and response data select
 */
`timescale 1ns/1ps
`include "c64_host_defs.svh"

module phase_bus_ctrl
  import host_bus_pkg::*;
(
  input  logic                    clk_8mhz,
  input  logic                    rst,
  input  host_req_t               i_bus,
  output host_rsp_t               o_bus,
  output region_e                 o_region,
  output phase_t                  o_phase,
  input  logic [`HOST_DATA_W-1:0] i_work_rdata,
  input  logic [`HOST_DATA_W-1:0] i_pad_rdata,
  input  logic [`HOST_DATA_W-1:0] i_ctrl_rdata,
  input  logic                    i_osd_busy,
  input  logic                    i_load_done
);

  logic [`PHASE_CNT_W-1:0] phase_cnt;
  logic                    ready_q;
  logic                    ready_d;
  logic                    is_write;
  logic [`HOST_DATA_W-1:0] rdata;
  region_e                 region;

  //////////////////////////////////////////////////////////////////////
  // phase enables

  always_ff @(posedge clk_8mhz) begin
    if (rst) begin
      phase_cnt <= '0;
    end else begin
      phase_cnt <= phase_cnt + 1'b1;
    end
  end

  // ph1 at count 0, ph2 half a period later
  assign o_phase = '{
    ph1: (phase_cnt == '0),
    ph2: (phase_cnt == {1'b1, {(`PHASE_CNT_W-1){1'b0}}})
  };

  //////////////////////////////////////////////////////////////////////
  // region decode

  always_comb begin
    case (i_bus.addr[`HOST_ADDR_W-1 -: 4])
      `REGION_ROM_TOP: region = UNMAPPED;
      `REGION_WORK:    region = WORK;
      `REGION_PAD:     region = PAD;
      `REGION_CTRL:    region = CTRL;
      default: begin
        region = (i_bus.addr[`HOST_ADDR_W-1 -: 16] == `LOADER_BASE_HI) ? LOADER : UNMAPPED;
      end
    endcase
  end

  assign o_region = region;
  assign is_write = (i_bus.wstrb != '0);

  //////////////////////////////////////////////////////////////////////
  // ready

  always_comb begin
    // base rule: one cycle after valid, never twice in a row
    ready_d = i_bus.valid && !ready_q;
    case (region)
      // osd fetch owns the work ram this cycle
      WORK:    ready_d = ready_d && !i_osd_busy;
      // loader writes finish on the ph1 after their ph2
      LOADER:  ready_d = ready_d && (!is_write || i_load_done);
      default: ;
    endcase
  end

  always_ff @(posedge clk_8mhz) begin
    if (rst) begin
      ready_q <= 1'b0;
    end else begin
      ready_q <= ready_d;
    end
  end

  // loader and unmapped reads come back as zero
  always_comb begin
    case (region)
      WORK:    rdata = i_work_rdata;
      PAD:     rdata = i_pad_rdata;
      CTRL:    rdata = i_ctrl_rdata;
      default: rdata = '0;
    endcase
  end

  assign o_bus = '{ready: ready_q, rdata: rdata};

endmodule

// ==== ctrl_regs.sv ====
/*
 * osd, keyboard mask and core control registers,
 * controller key readback and joystick port routing
 */
`timescale 1ns/1ps
`include "c64_host_defs.svh"

module ctrl_regs
  import host_bus_pkg::*;
  import video_pkg::*;
(
  input  logic                    clk_8mhz,
  input  logic                    rst,
  input  host_req_t               i_bus,
  input  region_e                 i_region,
  input  logic [15:0]             i_pad1_key,
  input  logic [15:0]             i_pad2_key,
  output logic [`HOST_DATA_W-1:0] o_pad_rdata,
  output logic [`HOST_DATA_W-1:0] o_ctrl_rdata,
  output osd_ctrl_t               o_osd_ctrl,
  output logic [6:0]              o_core_ctrl,
  output logic [63:0]             o_keyboard_mask,
  output logic [4:0]              o_joystick1,
  output logic [4:0]              o_joystick2
);

  logic [27:0] ofs;
  logic        wr_full;

  // select 1 = pad1, 2 = pad2, else idle
  function automatic logic [4:0] joy_route(input logic [1:0]  sel,
                                           input logic [15:0] pad1,
                                           input logic [15:0] pad2);
    case (sel)
      2'd1:    return pad1[4:0];
      2'd2:    return pad2[4:0];
      default: return 5'd0;
    endcase
  endfunction

  assign ofs = i_bus.addr[27:0];

  // only full-word writes touch the registers
  assign wr_full = i_bus.valid && (i_region == CTRL) && (i_bus.wstrb == 4'hf);

  always_ff @(posedge clk_8mhz) begin
    if (rst) begin
      o_osd_ctrl      <= '0;
      o_keyboard_mask <= '0;
      o_core_ctrl     <= '0;
    end else if (wr_full) begin
      case (ofs)
        `CTRL_OSD_OFS:    o_osd_ctrl <= osd_ctrl_t'(i_bus.wdata[1:0]);
        `CTRL_KBD_LO_OFS: o_keyboard_mask[31:0] <= i_bus.wdata;
        `CTRL_KBD_HI_OFS: o_keyboard_mask[63:32] <= i_bus.wdata;
        `CTRL_CORE_OFS:   o_core_ctrl <= i_bus.wdata[6:0];
        default: ;
      endcase
    end
  end

  // core ctrl [2:1] -> port 1, [4:3] -> port 2
  assign o_joystick1 = joy_route(o_core_ctrl[2:1], i_pad1_key, i_pad2_key);
  assign o_joystick2 = joy_route(o_core_ctrl[4:3], i_pad1_key, i_pad2_key);

  always_comb begin
    case (ofs)
      `PAD1_OFS: o_pad_rdata = {16'h0000, i_pad1_key};
      `PAD2_OFS: o_pad_rdata = {16'h0000, i_pad2_key};
      default:   o_pad_rdata = '0;
    endcase
  end

  assign o_ctrl_rdata = (ofs == `CTRL_CORE_OFS) ? {25'h0, o_core_ctrl} : '0;

endmodule

// ==== main_ram_loader.sv ====
/*
 * byte loader into the 64 KB main ram, aligned to the 1 MHz phases,
 * plus the core-side read port
 */
`timescale 1ns/1ps
`include "c64_host_defs.svh"

module main_ram_loader
  import host_bus_pkg::*;
(
  input  logic               clk_8mhz,
  input  logic               rst,
  input  host_req_t          i_bus,
  input  region_e            i_region,
  input  phase_t             i_phase,
  input  logic [`MAIN_AW-1:0] i_core_addr,
  output logic [7:0]         o_core_ram_data,
  output logic               o_load_done
);

  logic                load_req;
  logic                hold_q;
  logic                lane_ok;
  logic [1:0]          lane;
  logic [7:0]          load_byte;
  logic [`MAIN_AW-1:0] load_addr;
  logic [`MAIN_AW-1:0] ram_addr;
  logic [3:0]          ram_we;

  // one-hot strobe picks the byte lane
  always_comb begin
    lane_ok = 1'b1;
    case (i_bus.wstrb)
      4'b0001: lane = 2'd0;
      4'b0010: lane = 2'd1;
      4'b0100: lane = 2'd2;
      4'b1000: lane = 2'd3;
      default: begin
        lane    = 2'd0;
        lane_ok = 1'b0;
      end
    endcase
  end

  assign load_byte = i_bus.wdata[{lane, 3'b000} +: 8];
  assign load_addr = {i_bus.addr[`MAIN_AW-1:2], lane};
  assign load_req  = i_bus.valid && (i_region == LOADER) && (i_bus.wstrb != 4'h0);

  // hold the write across the whole ph2 half, drop at ph1
  always_ff @(posedge clk_8mhz) begin
    if (rst) begin
      hold_q <= 1'b0;
    end else if (i_phase.ph2) begin
      hold_q <= load_req;
    end else if (i_phase.ph1) begin
      hold_q <= 1'b0;
    end
  end

  assign o_load_done = hold_q && i_phase.ph1;

  // loader takes the address while held; bad strobes complete but write nothing
  assign ram_addr = hold_q ? load_addr : i_core_addr;
  assign ram_we   = {3'b000, hold_q && lane_ok};

  sync_ram #(
    .payload_t (logic [7:0]),
    .AW        (`MAIN_AW),
    .BYTE_WE   (1'b0)
  ) u_main_ram (
    .clk_8mhz (clk_8mhz),
    .i_addr   (ram_addr),
    .i_wdata  (load_byte),
    .i_we     (ram_we),
    .o_rdata  (o_core_ram_data)
  );

endmodule

// ==== osd_overlay.sv ====
/*
 * osd: shared work ram (osd has priority), pixel counters,
 * byte fetch, pixel shifter and colour mix over core video
 */
`timescale 1ns/1ps
`include "c64_host_defs.svh"

module osd_overlay
  import host_bus_pkg::*;
  import video_pkg::*;
(
  input  logic                    clk_8mhz,
  input  logic                    rst,
  input  host_req_t               i_bus,
  input  region_e                 i_region,
  input  osd_ctrl_t               i_osd_ctrl,
  input  video_beat_t             i_core_video,
  output video_beat_t             o_video,
  output logic [`HOST_DATA_W-1:0] o_work_rdata,
  output logic                    o_osd_busy
);

  typedef logic [`HOST_DATA_W-1:0] word_t;

  logic [8:0]          osd_x;
  logic [8:0]          osd_y;
  logic                y_in_window;
  logic                osd_active;
  logic [`WORK_AW+1:0] osd_byte_addr;
  logic [`WORK_AW-1:0] ram_addr;
  logic [3:0]          ram_we;
  word_t               ram_rdata;
  logic                fetch_p;
  logic [1:0]          lane_p;
  logic [7:0]          fetch_byte;
  logic [7:0]          pix_shift;
  logic [23:0]         osd_rgb;

  //////////////////////////////////////////////////////////////////////
  // beam position

  always_ff @(posedge clk_8mhz) begin
    if (rst) begin
      osd_x <= '0;
      osd_y <= '0;
    end else if (i_core_video.vs) begin
      osd_y <= '0;
    end else if (i_core_video.hs) begin
      osd_x <= '0;
      // x nonzero means the line had visible pixels
      if (osd_x != '0) begin
        osd_y <= osd_y + 1'b1;
      end
    end else if (i_core_video.de) begin
      osd_x <= osd_x + 1'b1;
    end
  end

  assign y_in_window = i_osd_ctrl.tall ? (osd_y < 9'd64) : (osd_y < 9'd8);
  assign osd_active  = i_osd_ctrl.enable && i_core_video.de && !osd_x[8] && y_in_window;
  assign o_osd_busy  = osd_active && (osd_x[2:0] == 3'd0);

  // 32 bytes per line; lines past 31 wrap in the 1 KB ram
  assign osd_byte_addr = {osd_y[`WORK_AW-4:0], osd_x[7:3]};

  //////////////////////////////////////////////////////////////////////
  // work ram, cpu gets the port when no fetch is due

  assign ram_addr = o_osd_busy ? osd_byte_addr[`WORK_AW+1:2] : i_bus.addr[`WORK_AW+1:2];
  assign ram_we   = (!o_osd_busy && i_bus.valid && (i_region == WORK)) ? i_bus.wstrb : 4'h0;

  sync_ram #(
    .payload_t (word_t),
    .AW        (`WORK_AW),
    .BYTE_WE   (1'b1)
  ) u_work_ram (
    .clk_8mhz (clk_8mhz),
    .i_addr   (ram_addr),
    .i_wdata  (i_bus.wdata),
    .i_we     (ram_we),
    .o_rdata  (ram_rdata)
  );

  assign o_work_rdata = ram_rdata;

  //////////////////////////////////////////////////////////////////////
  // fetch and shift, msb first

  always_ff @(posedge clk_8mhz) begin
    if (rst) begin
      fetch_p <= 1'b0;
    end else begin
      fetch_p <= o_osd_busy;
    end
  end

  assign fetch_byte = ram_rdata[{lane_p, 3'b000} +: 8];

  always_ff @(posedge clk_8mhz) begin
    lane_p <= osd_byte_addr[1:0];
    if (fetch_p) begin
      pix_shift <= fetch_byte;
    end else begin
      pix_shift <= {pix_shift[6:0], 1'b0};
    end
  end

  assign osd_rgb = pix_shift[7] ? `OSD_FG_RGB : `OSD_BG_RGB;

  // syncs pass straight through
  always_comb begin
    o_video = i_core_video;
    if (!i_core_video.de) begin
      o_video.rgb = '0;
    end else if (osd_active) begin
      o_video.rgb = osd_rgb;
    end
  end

endmodule

// ==== c64_host_top.sv ====
/*
 * host control plane top: bus control, registers, loader, osd
 */
`timescale 1ns/1ps
`include "c64_host_defs.svh"

module c64_host_top
  import host_bus_pkg::*;
  import video_pkg::*;
(
  input  logic                clk_8mhz,
  input  logic                rst,
  input  host_req_t           i_bus,
  output host_rsp_t           o_bus,
  input  logic [15:0]         i_pad1_key,
  input  logic [15:0]         i_pad2_key,
  input  video_beat_t         i_core_video,
  output video_beat_t         o_video,
  input  logic [`MAIN_AW-1:0] i_core_addr,
  output logic [7:0]          o_core_ram_data,
  output logic [4:0]          o_joystick1,
  output logic [4:0]          o_joystick2,
  output logic [63:0]         o_keyboard_mask,
  output logic [6:0]          o_core_ctrl
);

  region_e                 region;
  phase_t                  phase;
  osd_ctrl_t               osd_ctrl;
  logic [`HOST_DATA_W-1:0] work_rdata;
  logic [`HOST_DATA_W-1:0] pad_rdata;
  logic [`HOST_DATA_W-1:0] ctrl_rdata;
  logic                    osd_busy;
  logic                    load_done;

  phase_bus_ctrl u_phase_bus_ctrl (
    .clk_8mhz     (clk_8mhz),
    .rst          (rst),
    .i_bus        (i_bus),
    .o_bus        (o_bus),
    .o_region     (region),
    .o_phase      (phase),
    .i_work_rdata (work_rdata),
    .i_pad_rdata  (pad_rdata),
    .i_ctrl_rdata (ctrl_rdata),
    .i_osd_busy   (osd_busy),
    .i_load_done  (load_done)
  );

  ctrl_regs u_ctrl_regs (
    .clk_8mhz        (clk_8mhz),
    .rst             (rst),
    .i_bus           (i_bus),
    .i_region        (region),
    .i_pad1_key      (i_pad1_key),
    .i_pad2_key      (i_pad2_key),
    .o_pad_rdata     (pad_rdata),
    .o_ctrl_rdata    (ctrl_rdata),
    .o_osd_ctrl      (osd_ctrl),
    .o_core_ctrl     (o_core_ctrl),
    .o_keyboard_mask (o_keyboard_mask),
    .o_joystick1     (o_joystick1),
    .o_joystick2     (o_joystick2)
  );

  main_ram_loader u_main_ram_loader (
    .clk_8mhz        (clk_8mhz),
    .rst             (rst),
    .i_bus           (i_bus),
    .i_region        (region),
    .i_phase         (phase),
    .i_core_addr     (i_core_addr),
    .o_core_ram_data (o_core_ram_data),
    .o_load_done     (load_done)
  );

  osd_overlay u_osd_overlay (
    .clk_8mhz     (clk_8mhz),
    .rst          (rst),
    .i_bus        (i_bus),
    .i_region     (region),
    .i_osd_ctrl   (osd_ctrl),
    .i_core_video (i_core_video),
    .o_video      (o_video),
    .o_work_rdata (work_rdata),
    .o_osd_busy   (osd_busy)
  );

endmodule

// ==== c64_host_asserts.sv ====
/*
 * concurrent assertions on the host bus handshake and the
 * 1 MHz phase enables, bound into phase_bus_ctrl
 */
`timescale 1ns/1ps

module c64_host_asserts (
  input logic clk_8mhz,
  input logic rst,
  input logic i_valid,
  input logic i_ready,
  input logic i_ph1,
  input logic i_ph2
);

  int         fail_cnt = 0;
  logic [3:0] run_cnt;

  // cycles since reset, saturating
  always_ff @(posedge clk_8mhz) begin
    if (rst) begin
      run_cnt <= '0;
    end else if (run_cnt != 4'hf) begin
      run_cnt <= run_cnt + 1'b1;
    end
  end

  a_ready_pulse: assert property (@(posedge clk_8mhz) disable iff (rst) i_ready |=> !i_ready)
    else begin fail_cnt++; $error("ready high for more than one cycle"); end

  a_ready_valid: assert property (@(posedge clk_8mhz) disable iff (rst) i_ready |-> i_valid)
    else begin fail_cnt++; $error("ready without valid"); end

  a_phase_excl: assert property (@(posedge clk_8mhz) disable iff (rst) !(i_ph1 && i_ph2))
    else begin fail_cnt++; $error("ph1 and ph2 high together"); end

  a_ph2_gap: assert property (@(posedge clk_8mhz) disable iff (rst) i_ph2 |-> $past(i_ph1, 4))
    else begin fail_cnt++; $error("ph2 not 4 cycles after ph1"); end

  // first ph1 after reset has no ph2 before it
  a_ph1_gap: assert property (@(posedge clk_8mhz) disable iff (rst)
                              (i_ph1 && run_cnt >= 4'd8) |-> $past(i_ph2, 4))
    else begin fail_cnt++; $error("ph1 not 4 cycles after ph2"); end

endmodule

bind phase_bus_ctrl c64_host_asserts u_asserts (
  .clk_8mhz (clk_8mhz),
  .rst      (rst),
  .i_valid  (i_bus.valid),
  .i_ready  (o_bus.ready),
  .i_ph1    (o_phase.ph1),
  .i_ph2    (o_phase.ph2)
);

// ==== tb_c64_host.sv ====
/*
 * testbench for the host control plane: clock and reset, bus master
 * tasks, reference model of registers, work ram and main ram,
 * compare process, watchdog and closing report
 */
`timescale 1ns/1ps
`include "c64_host_defs.svh"

module tb_c64_host
  import host_bus_pkg::*;
  import video_pkg::*;
();

  localparam int CLK_PERIOD   = 40;
  localparam int DRIVE_DLY    = 2;
  localparam int RESET_CYCLES = 10;
  localparam int HS_TIMEOUT   = 32;
  // per-test cycle budgets in test order
  localparam int TEST_BUDGET     = 200 + 300 + 600 + 800 + 1000 + 4000;
  localparam int WATCHDOG_CYCLES = 2 * (RESET_CYCLES + TEST_BUDGET);

  logic        clk_8mhz;
  logic        rst;
  host_req_t   bus_req;
  host_rsp_t   bus_rsp;
  logic [15:0] pad1_key;
  logic [15:0] pad2_key;
  video_beat_t core_video;
  video_beat_t video_out;
  logic [15:0] core_addr;
  logic [7:0]  core_ram_data;
  logic [4:0]  joy1;
  logic [4:0]  joy2;
  logic [63:0] kbd_mask;
  logic [6:0]  core_ctrl;

  // reference model state
  logic [7:0]  work_mem [1024];
  logic [7:0]  main_mem [65536];
  logic [63:0] m_kbd;
  logic [6:0]  m_core;
  logic [1:0]  m_osd;
  logic [15:0] load_addrs [12];

  logic [31:0] exp_q [$];
  logic [31:0] got_q [$];
  string       name_q [$];
  integer      seed;
  int          err_cnt;
  int          check_cnt;
  int          test_num;
  int          err_base;
  int          asrt_fails;

  c64_host_top DUT (
    .clk_8mhz        (clk_8mhz),
    .rst             (rst),
    .i_bus           (bus_req),
    .o_bus           (bus_rsp),
    .i_pad1_key      (pad1_key),
    .i_pad2_key      (pad2_key),
    .i_core_video    (core_video),
    .o_video         (video_out),
    .i_core_addr     (core_addr),
    .o_core_ram_data (core_ram_data),
    .o_joystick1     (joy1),
    .o_joystick2     (joy2),
    .o_keyboard_mask (kbd_mask),
    .o_core_ctrl     (core_ctrl)
  );

  initial begin
    clk_8mhz = 1'b0;
    forever #(CLK_PERIOD / 2) clk_8mhz = ~clk_8mhz;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_8mhz);
    $display("watchdog expired after %0d cycles, run did not finish", WATCHDOG_CYCLES);
    $display("sim failed");
    $finish;
  end

  //////////////////////////////////////////////////////////////////////
  // reference model

  // expected bus read data or main ram byte on the core port
  function automatic logic [31:0] model_expect(input bit core_port, input logic [31:0] addr);
    if (core_port) begin
      return {24'h0, main_mem[addr[15:0]]};
    end
    case (addr[31:28])
      `REGION_WORK: return {work_mem[{addr[9:2], 2'd3}], work_mem[{addr[9:2], 2'd2}],
                            work_mem[{addr[9:2], 2'd1}], work_mem[{addr[9:2], 2'd0}]};
      `REGION_PAD: begin
        if (addr[27:0] == 28'h0) return {16'h0, pad1_key};
        if (addr[27:0] == 28'h4) return {16'h0, pad2_key};
        return 32'h0;
      end
      `REGION_CTRL: return (addr[27:0] == 28'hc) ? {25'h0, m_core} : 32'h0;
      default: return 32'h0;
    endcase
  endfunction

  function automatic logic [4:0] joy_expect(input logic [1:0] sel);
    case (sel)
      2'd1:    return pad1_key[4:0];
      2'd2:    return pad2_key[4:0];
      default: return 5'd0;
    endcase
  endfunction

  task automatic model_store(input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] strb);
    logic [1:0] lane;
    if (addr[31:16] == `LOADER_BASE_HI) begin
      // only a one-hot strobe names a byte
      if ($onehot(strb)) begin
        lane = (strb[1] ? 2'd1 : 2'd0) | (strb[2] ? 2'd2 : 2'd0) | (strb[3] ? 2'd3 : 2'd0);
        main_mem[{addr[15:2], lane}] = data[{lane, 3'b000} +: 8];
      end
    end else if (addr[31:28] == `REGION_WORK) begin
      for (int b = 0; b < 4; b++) begin
        if (strb[b]) work_mem[{addr[9:2], b[1:0]}] = data[b*8 +: 8];
      end
    end else if (addr[31:28] == `REGION_CTRL && strb == 4'hf) begin
      case (addr[27:0])
        28'h0:   m_osd = data[1:0];
        28'h4:   m_kbd[31:0] = data;
        28'h8:   m_kbd[63:32] = data;
        28'hc:   m_core = data[6:0];
        default: ;
      endcase
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // checking

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("[ERROR] %0t %s: expected 0x%08h, got 0x%08h", $time, name, exp, got);
    end
  endtask

  task automatic queue_check(input string name, input logic [31:0] exp, input logic [31:0] got);
    name_q.push_back(name);
    exp_q.push_back(exp);
    got_q.push_back(got);
  endtask

  // compare process
  initial begin
    forever begin
      @(negedge clk_8mhz);
      while (got_q.size() > 0) begin
        check_value(name_q.pop_front(), exp_q.pop_front(), got_q.pop_front());
      end
    end
  end

  task automatic end_test(input string name);
    while (got_q.size() > 0) @(posedge clk_8mhz);
    test_num++;
    $display("test %0d %s done, %0d errors", test_num, name, err_cnt - err_base);
    err_base = err_cnt;
  endtask

  //////////////////////////////////////////////////////////////////////
  // bus master

  task automatic drive_step();
    @(posedge clk_8mhz);
    #DRIVE_DLY;
  endtask

  task automatic bus_access(input logic [31:0] addr, input logic [31:0] wdata,
                            input logic [3:0] wstrb, output logic [31:0] rdata);
    int waited;
    waited = 0;
    rdata = '0;
    drive_step();
    bus_req = '{valid: 1'b1, addr: addr, wdata: wdata, wstrb: wstrb};
    @(negedge clk_8mhz);
    while (!bus_rsp.ready && waited < HS_TIMEOUT) begin
      @(negedge clk_8mhz);
      waited++;
    end
    if (bus_rsp.ready) begin
      rdata = bus_rsp.rdata;
    end else begin
      err_cnt++;
      $display("bus access to 0x%08h got no ready within %0d cycles", addr, HS_TIMEOUT);
    end
    // valid stays up through the ready cycle
    drive_step();
    bus_req = '0;
  endtask

  task automatic bus_write(input logic [31:0] addr, input logic [31:0] data,
                           input logic [3:0] strb);
    logic [31:0] unused;
    bus_access(addr, data, strb, unused);
    model_store(addr, data, strb);
  endtask

  task automatic bus_read(input logic [31:0] addr, output logic [31:0] data);
    bus_access(addr, 32'h0, 4'h0, data);
  endtask

  task automatic read_check(input string name, input logic [31:0] addr);
    logic [31:0] rdata;
    bus_read(addr, rdata);
    queue_check(name, model_expect(1'b0, addr), rdata);
  endtask

  task automatic core_read_check(input logic [15:0] a);
    drive_step();
    core_addr = a;
    @(posedge clk_8mhz);
    @(negedge clk_8mhz);
    queue_check("o_core_ram_data", model_expect(1'b1, {16'h0, a}), {24'h0, core_ram_data});
  endtask

  task automatic check_reg_outputs();
    @(negedge clk_8mhz);
    queue_check("o_keyboard_mask[31:0]", m_kbd[31:0], kbd_mask[31:0]);
    queue_check("o_keyboard_mask[63:32]", m_kbd[63:32], kbd_mask[63:32]);
    queue_check("o_core_ctrl", {25'h0, m_core}, {25'h0, core_ctrl});
  endtask

  // one video beat, osd pixels trail their fetch by two beats
  task automatic video_beat(input logic hs, input logic vs, input logic de,
                            input int x, input int y);
    logic [31:0] rnd;
    logic [23:0] exp_rgb;
    logic [7:0]  pix_byte;
    int          px;
    bit          in_win;
    rnd = $random(seed);
    drive_step();
    core_video = '{rgb: rnd[23:0], hs: hs, vs: vs, de: de};
    in_win = m_osd[0] && de && (x < 256) && (y < (m_osd[1] ? 64 : 8));
    px = x - 2;
    exp_rgb = de ? rnd[23:0] : 24'h0;
    if (in_win && x >= 2) begin
      pix_byte = work_mem[{y[4:0], px[7:3]}];
      exp_rgb = pix_byte[~px[2:0]] ? `OSD_FG_RGB : `OSD_BG_RGB;
    end
    @(negedge clk_8mhz);
    queue_check("o_video.sync", {29'h0, hs, vs, de},
                {29'h0, video_out.hs, video_out.vs, video_out.de});
    // first two window pixels carry no fetched data yet
    if (!in_win || x >= 2) begin
      queue_check("o_video.rgb", {8'h0, exp_rgb}, {8'h0, video_out.rgb});
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // tests

  task automatic after_reset();
    for (int i = 0; i < 4; i++) begin
      @(negedge clk_8mhz);
      queue_check("o_bus.ready", 32'h0, {31'h0, bus_rsp.ready});
      queue_check("o_joystick1", 32'h0, {27'h0, joy1});
      queue_check("o_joystick2", 32'h0, {27'h0, joy2});
    end
    check_reg_outputs();
    for (int i = 0; i < 16; i++) begin
      video_beat(1'b0, 1'b0, i[0] ^ i[2], 0, 0);
    end
    drive_step();
    core_video = '0;
    read_check("unmapped rdata", 32'h0000_0010);
    read_check("unmapped rdata", 32'h4000_0000);
    end_test("reset");
  endtask

  task automatic register_writes();
    logic [31:0] rnd;
    rnd = $random(seed);
    bus_write({`REGION_CTRL, `CTRL_KBD_LO_OFS}, rnd, 4'hf);
    rnd = $random(seed);
    bus_write({`REGION_CTRL, `CTRL_KBD_HI_OFS}, rnd, 4'hf);
    rnd = $random(seed);
    bus_write({`REGION_CTRL, `CTRL_CORE_OFS}, rnd, 4'hf);
    check_reg_outputs();
    read_check("ctrl core rdata", {`REGION_CTRL, `CTRL_CORE_OFS});
    read_check("ctrl kbd rdata", {`REGION_CTRL, `CTRL_KBD_LO_OFS});
    read_check("ctrl osd rdata", {`REGION_CTRL, `CTRL_OSD_OFS});
    // partial strobes leave every register alone
    bus_write({`REGION_CTRL, `CTRL_KBD_LO_OFS}, ~m_kbd[31:0], 4'h7);
    bus_write({`REGION_CTRL, `CTRL_KBD_HI_OFS}, ~m_kbd[63:32], 4'h1);
    bus_write({`REGION_CTRL, `CTRL_CORE_OFS}, ~rnd, 4'he);
    check_reg_outputs();
    read_check("ctrl core rdata", {`REGION_CTRL, `CTRL_CORE_OFS});
    end_test("regs");
  endtask

  task automatic joystick_routing();
    logic [31:0] rnd;
    for (int s1 = 0; s1 < 4; s1++) begin
      for (int s2 = 0; s2 < 4; s2++) begin
        rnd = $random(seed);
        bus_write({`REGION_CTRL, `CTRL_CORE_OFS},
                  {25'h0, rnd[6:5], s2[1:0], s1[1:0], rnd[0]}, 4'hf);
        rnd = $random(seed);
        drive_step();
        pad1_key = rnd[15:0];
        pad2_key = rnd[31:16];
        @(negedge clk_8mhz);
        queue_check("o_joystick1", {27'h0, joy_expect(m_core[2:1])}, {27'h0, joy1});
        queue_check("o_joystick2", {27'h0, joy_expect(m_core[4:3])}, {27'h0, joy2});
        read_check("pad1 rdata", {`REGION_PAD, `PAD1_OFS});
        read_check("pad2 rdata", {`REGION_PAD, `PAD2_OFS});
      end
    end
    read_check("pad rdata", {`REGION_PAD, 28'h8});
    end_test("joystick");
  endtask

  task automatic work_ram_rw();
    logic [31:0] rnd;
    logic [31:0] addr;
    for (int i = 0; i < 8; i++) begin
      rnd = $random(seed);
      addr = {`REGION_WORK, 18'h0, rnd[7:0], 2'b00};
      rnd = $random(seed);
      bus_write(addr, rnd, 4'hf);
      for (int j = 0; j < 3; j++) begin
        rnd = $random(seed);
        bus_write(addr, rnd, rnd[11:8]);
      end
      read_check("work rdata", addr);
    end
    end_test("work_ram");
  endtask

  task automatic loader_writes();
    logic [31:0] rnd;
    logic [15:0] a;
    logic [3:0]  bad_strb [3];
    bad_strb[0] = 4'b0011;
    bad_strb[1] = 4'b1111;
    bad_strb[2] = 4'b0101;
    for (int i = 0; i < 12; i++) begin
      rnd = $random(seed);
      a = rnd[15:0];
      load_addrs[i] = a;
      rnd = $random(seed);
      bus_write({`LOADER_BASE_HI, a[15:2], 2'b00}, rnd, 4'b0001 << a[1:0]);
    end
    for (int i = 0; i < 12; i++) begin
      core_read_check(load_addrs[i]);
    end
    read_check("loader rdata", {`LOADER_BASE_HI, 16'h0010});
    for (int i = 0; i < 3; i++) begin
      a = load_addrs[i];
      // fill the whole word so a stray lane write shows up
      for (int k = 0; k < 4; k++) begin
        rnd = $random(seed);
        bus_write({`LOADER_BASE_HI, a[15:2], 2'b00}, rnd, 4'b0001 << k);
      end
      rnd = $random(seed);
      bus_write({`LOADER_BASE_HI, a[15:2], 2'b00}, rnd, bad_strb[i]);
      for (int k = 0; k < 4; k++) begin
        core_read_check({a[15:2], k[1:0]});
      end
    end
    end_test("loader");
  endtask

  task automatic osd_frame();
    logic [31:0] rnd;
    for (int w = 0; w < 64; w++) begin
      rnd = $random(seed);
      bus_write({`REGION_WORK, 18'h0, w[7:0], 2'b00}, rnd, 4'hf);
    end
    bus_write({`REGION_CTRL, `CTRL_OSD_OFS}, 32'h1, 4'hf);
    // hs then vs puts the beam at the top left
    video_beat(1'b1, 1'b0, 1'b0, 0, 0);
    video_beat(1'b0, 1'b1, 1'b0, 0, 0);
    for (int line = 0; line < 9; line++) begin
      video_beat(1'b1, 1'b0, 1'b0, 0, line);
      repeat (3) video_beat(1'b0, 1'b0, 1'b0, 0, line);
      for (int x = 0; x < 272; x++) begin
        video_beat(1'b0, 1'b0, 1'b1, x, line);
      end
      repeat (4) video_beat(1'b0, 1'b0, 1'b0, 0, line);
    end
    end_test("osd");
  endtask

  initial begin
    seed = 32'h11c8;
    rst = 1'b1;
    bus_req = '0;
    // nonzero keys so idle joystick ports are really tested
    pad1_key = 16'h1f1f;
    pad2_key = 16'h2e2e;
    core_video = '0;
    core_addr = '0;
    m_kbd = '0;
    m_core = '0;
    m_osd = '0;
    err_cnt = 0;
    check_cnt = 0;
    test_num = 0;
    err_base = 0;
    repeat (RESET_CYCLES) @(posedge clk_8mhz);
    #DRIVE_DLY;
    rst = 1'b0;
    after_reset();
    register_writes();
    joystick_routing();
    work_ram_rw();
    loader_writes();
    osd_frame();
    asrt_fails = DUT.u_phase_bus_ctrl.u_asserts.fail_cnt;
    $display("%0d tests, %0d checks, %0d errors, %0d assertion failures",
             test_num, check_cnt, err_cnt, asrt_fails);
    if (err_cnt == 0 && asrt_fails == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// ==== c64_host.f ====
+incdir+.
host_bus_pkg.sv
video_pkg.sv
sync_ram.sv
phase_bus_ctrl.sv
ctrl_regs.sv
main_ram_loader.sv
osd_overlay.sv
c64_host_top.sv
c64_host_asserts.sv
tb_c64_host.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the host control plane testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_c64_host -f c64_host.f -o sim_c64_host

out=$(./obj_dir/sim_c64_host +verilator+error+limit+100)
echo "$out"

# the run passes only if the testbench reported a pass
echo "$out" | grep -qx "sim passed"
